//--- hdl/fir_cfg.svh
// FIR filter constants
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH
`default_nettype none

// filter length and data widths
`define FIR_NUM_TAPS    15
`define FIR_SAMPLE_BITS 10
`define FIR_COEFF_BITS  17
`define FIR_ACC_BITS    32
// sum is divided by 2^15 before it is returned
`define FIR_SCALE_SHIFT 15

`default_nettype wire
`endif

//--- hdl/fir_pkg.sv
// FIR shared types
`include "fir_cfg.svh"
`default_nettype none

package fir_pkg;

	// one input sample, two's complement
	typedef logic signed [`FIR_SAMPLE_BITS-1:0] sample_t;

	// one filter coefficient
	typedef logic signed [`FIR_COEFF_BITS-1:0] coeff_t;

	// running sum and the scaled result
	typedef logic signed [`FIR_ACC_BITS-1:0] acc_t;

	typedef logic [3:0] tap_idx_t;
	// counts up to 32 output bits
	typedef logic [5:0] bit_cnt_t;

endpackage

`default_nettype wire

//--- hdl/sample_deserializer.sv
// Serial sample input
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module sample_deserializer
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    shift_en,
	input  logic    data_in,
	output logic    in_busy,
	output logic    sample_req,
	input  logic    sample_ack,
	output sample_t sample
);

	sample_t  shift_reg;
	bit_cnt_t bit_cnt;
	logic     full;

	assign full = (bit_cnt == bit_cnt_t'(`FIR_SAMPLE_BITS));

	// source must wait while a finished sample is still pending
	assign in_busy = full;
	assign sample  = shift_reg;

	//////////////////////////////////////////////////
	// bit capture, msb first
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (shift_en && !full)
		begin
			shift_reg <= {shift_reg[`FIR_SAMPLE_BITS-2:0], data_in};
		end
	end

	//////////////////////////////////////////////////
	// bit count and request side of the handshake
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bit_cnt    <= '0;
			sample_req <= 1'b0;
		end
		else
		begin
			if (shift_en && !full)
			begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			// offer only once the framing window has closed
			if (full && !shift_en && !sample_req && !sample_ack)
			begin
				sample_req <= 1'b1;
			end
			else if (sample_req && sample_ack)
			begin
				sample_req <= 1'b0;
				bit_cnt    <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tap_delay_line.sv
// Tap delay line
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module tap_delay_line
	import fir_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  sample_t  push_sample,
	input  tap_idx_t rd_index,
	output sample_t  rd_sample
);

	// index 0 holds the newest sample
	sample_t hist [`FIR_NUM_TAPS];

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < `FIR_NUM_TAPS; i++)
			begin
				hist[i] <= '0;
			end
		end
		else if (push)
		begin
			for (int i = `FIR_NUM_TAPS - 1; i > 0; i--)
			begin
				hist[i] <= hist[i-1];
			end
			hist[0] <= push_sample;
		end
	end

	// unused index codes read as zero
	assign rd_sample = (rd_index < `FIR_NUM_TAPS) ? hist[rd_index] : '0;

endmodule

`default_nettype wire

//--- hdl/coeff_rom.sv
// Coefficient table
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module coeff_rom
	import fir_pkg::*;
(
	input  tap_idx_t rd_index,
	output coeff_t   coeff
);

	//////////////////////////////////////////////////
	// symmetric 15 tap low pass, centre at index 7
	//////////////////////////////////////////////////
	always_comb
	begin
		case (rd_index)
			4'd0:    coeff = coeff_t'(318);
			4'd1:    coeff = coeff_t'(848);
			4'd2:    coeff = coeff_t'(1057);
			4'd3:    coeff = coeff_t'(861);
			4'd4:    coeff = coeff_t'(331);
			4'd5:    coeff = coeff_t'(-329);
			4'd6:    coeff = coeff_t'(-865);
			// centre tap, close to unity gain after the shift
			4'd7:    coeff = coeff_t'(31698);
			4'd8:    coeff = coeff_t'(-865);
			4'd9:    coeff = coeff_t'(-329);
			4'd10:   coeff = coeff_t'(331);
			4'd11:   coeff = coeff_t'(861);
			4'd12:   coeff = coeff_t'(1057);
			4'd13:   coeff = coeff_t'(848);
			4'd14:   coeff = coeff_t'(318);
			default: coeff = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/fir_mac.sv
// FIR multiply-accumulate engine
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module fir_mac
	import fir_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     sample_req,
	output logic     sample_ack,
	input  sample_t  sample,
	output logic     push,
	output sample_t  push_sample,
	output tap_idx_t rd_index,
	input  sample_t  rd_sample,
	input  coeff_t   coeff,
	output logic     result_req,
	input  logic     result_ack,
	output acc_t     result
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ACCEPT,
		ST_ACCUM,
		ST_SCALE,
		ST_OFFER
	} mac_state_t;

	mac_state_t state;
	tap_idx_t   tap;
	acc_t       acc;
	acc_t       product;

	// full width signed product, sign extended to the accumulator
	assign product = acc_t'(rd_sample) * acc_t'(coeff);

	// delay line shifts at the end of the accept cycle
	assign push        = (state == ST_ACCEPT);
	assign push_sample = sample;
	assign rd_index    = tap;

	//////////////////////////////////////////////////
	// control FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state      <= ST_IDLE;
			tap        <= '0;
			sample_ack <= 1'b0;
			result_req <= 1'b0;
		end
		else
		begin
			// ack falls once the deserializer has withdrawn its request
			if (sample_ack && !sample_req)
			begin
				sample_ack <= 1'b0;
			end
			case (state)
				ST_IDLE:
				begin
					if (sample_req && !sample_ack)
					begin
						sample_ack <= 1'b1;
						state      <= ST_ACCEPT;
					end
				end
				ST_ACCEPT:
				begin
					tap   <= '0;
					state <= ST_ACCUM;
				end
				ST_ACCUM:
				begin
					tap <= tap + 1'b1;
					if (tap == tap_idx_t'(`FIR_NUM_TAPS - 1))
					begin
						state <= ST_SCALE;
					end
				end
				ST_SCALE:
				begin
					result_req <= 1'b1;
					state      <= ST_OFFER;
				end
				ST_OFFER:
				begin
					// hold the request until the serializer takes the result
					if (result_ack)
					begin
						result_req <= 1'b0;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (state == ST_ACCEPT)
		begin
			acc <= '0;
		end
		else if (state == ST_ACCUM)
		begin
			acc <= acc + product;
		end
		if (state == ST_SCALE)
		begin
			result <= acc >>> `FIR_SCALE_SHIFT;
		end
	end

endmodule

`default_nettype wire

//--- hdl/result_serializer.sv
// Serial result output
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module result_serializer
	import fir_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic result_req,
	output logic result_ack,
	input  acc_t result,
	output logic data_out,
	output logic out_req,
	input  logic out_ack
);

	acc_t     shift_reg;
	bit_cnt_t bit_cnt;
	logic     busy;
	logic     load;
	logic     bit_done;

	// take a new result only when the previous one is fully sent
	assign load     = result_req && !result_ack && !busy;
	assign bit_done = out_req && out_ack;

	// lsb first, held while out_req is high
	assign data_out = shift_reg[0];

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			shift_reg <= result;
		end
		else if (bit_done)
		begin
			shift_reg <= shift_reg >> 1;
		end
	end

	//////////////////////////////////////////////////
	// result handshake and per bit handshake
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			busy       <= 1'b0;
			bit_cnt    <= '0;
			result_ack <= 1'b0;
			out_req    <= 1'b0;
		end
		else
		begin
			if (load)
			begin
				busy       <= 1'b1;
				bit_cnt    <= '0;
				result_ack <= 1'b1;
			end
			else if (result_ack && !result_req)
			begin
				result_ack <= 1'b0;
			end

			// next bit goes out only after the outside has dropped its ack
			if (busy && !out_req && !out_ack)
			begin
				out_req <= 1'b1;
			end
			else if (bit_done)
			begin
				out_req <= 1'b0;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == bit_cnt_t'(`FIR_ACC_BITS - 1))
				begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/fir_filter_top.sv
// Serial FIR filter top
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module fir_filter_top
	import fir_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic shift_en,
	input  logic data_in,
	output logic in_busy,
	output logic data_out,
	output logic out_req,
	input  logic out_ack
);

	// sample handshake
	logic     sample_req;
	logic     sample_ack;
	sample_t  sample;

	// delay line and coefficient access
	logic     push;
	sample_t  push_sample;
	tap_idx_t rd_index;
	sample_t  rd_sample;
	coeff_t   coeff;

	// result handshake
	logic     result_req;
	logic     result_ack;
	acc_t     result;

	//////////////////////////////////////////////////
	// input side
	//////////////////////////////////////////////////
	sample_deserializer u_deser (
		.clk        (clk),
		.reset      (reset),
		.shift_en   (shift_en),
		.data_in    (data_in),
		.in_busy    (in_busy),
		.sample_req (sample_req),
		.sample_ack (sample_ack),
		.sample     (sample)
	);

	//////////////////////////////////////////////////
	// filter core
	//////////////////////////////////////////////////
	fir_mac u_mac (
		.clk         (clk),
		.reset       (reset),
		.sample_req  (sample_req),
		.sample_ack  (sample_ack),
		.sample      (sample),
		.push        (push),
		.push_sample (push_sample),
		.rd_index    (rd_index),
		.rd_sample   (rd_sample),
		.coeff       (coeff),
		.result_req  (result_req),
		.result_ack  (result_ack),
		.result      (result)
	);

	tap_delay_line u_delay (
		.clk         (clk),
		.reset       (reset),
		.push        (push),
		.push_sample (push_sample),
		.rd_index    (rd_index),
		.rd_sample   (rd_sample)
	);

	coeff_rom u_coeff (
		.rd_index (rd_index),
		.coeff    (coeff)
	);

	//////////////////////////////////////////////////
	// output side
	//////////////////////////////////////////////////
	result_serializer u_ser (
		.clk        (clk),
		.reset      (reset),
		.result_req (result_req),
		.result_ack (result_ack),
		.result     (result),
		.data_out   (data_out),
		.out_req    (out_req),
		.out_ack    (out_ack)
	);

endmodule

`default_nettype wire

//--- verif/fir_assert.sv
// FIR protocol assertions
`timescale 1ns/1ps
`default_nettype none

module fir_assert
(
	input  logic clk,
	input  logic reset,
	input  logic in_busy,
	input  logic data_out,
	input  logic out_req,
	input  logic out_ack,
	input  logic sample_req,
	input  logic sample_ack,
	input  logic result_req,
	input  logic result_ack
);

	// read by the testbench monitor
	int violations = 0;

	//////////////////////////////////////////////////
	// four-phase output per bit
	//////////////////////////////////////////////////
	out_req_hold: assert property (@(posedge clk) disable iff (!reset)
		out_req && !out_ack |=> out_req)
	else
	begin
		violations++;
		$error("out_req fell before out_ack");
	end

	data_out_stable: assert property (@(posedge clk) disable iff (!reset)
		out_req |=> !out_req || $stable(data_out))
	else
	begin
		violations++;
		$error("data_out changed while out_req was high");
	end

	//////////////////////////////////////////////////
	// internal handshakes
	//////////////////////////////////////////////////
	sample_req_hold: assert property (@(posedge clk) disable iff (!reset)
		sample_req && !sample_ack |=> sample_req)
	else
	begin
		violations++;
		$error("sample_req fell before sample_ack");
	end

	result_req_hold: assert property (@(posedge clk) disable iff (!reset)
		result_req && !result_ack |=> result_req)
	else
	begin
		violations++;
		$error("result_req fell before result_ack");
	end

	// outputs quiet while reset is held
	reset_quiet: assert property (@(posedge clk) !reset |-> !in_busy && !out_req)
	else
	begin
		violations++;
		$error("in_busy or out_req high during reset");
	end

endmodule

bind fir_filter_top fir_assert u_assert (
	.clk        (clk),
	.reset      (reset),
	.in_busy    (in_busy),
	.data_out   (data_out),
	.out_req    (out_req),
	.out_ack    (out_ack),
	.sample_req (sample_req),
	.sample_ack (sample_ack),
	.result_req (result_req),
	.result_ack (result_ack)
);

`default_nettype wire

//--- verif/fir_tb.sv
// FIR filter testbench
`timescale 1ns/1ps
`include "fir_cfg.svh"
`default_nettype none

module fir_tb
	import fir_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_SAMPLES  = 18;
	// per sample: shift in, MAC, 32 slow output bits and some margin
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_SAMPLES *
		(`FIR_SAMPLE_BITS + `FIR_NUM_TAPS + `FIR_ACC_BITS * 14 + 20);

	logic clk;
	logic reset;
	logic shift_en;
	logic data_in;
	logic out_ack;
	logic in_busy;
	logic data_out;
	logic out_req;

	// even words hold samples, odd words the expected results
	logic [31:0] golden_mem [0:2*NUM_SAMPLES-1];

	// set while a result is coming back
	logic receiving;
	int   overlaps;

	fir_filter_top dut (
		.clk      (clk),
		.reset    (reset),
		.shift_en (shift_en),
		.data_in  (data_in),
		.in_busy  (in_busy),
		.data_out (data_out),
		.out_req  (out_req),
		.out_ack  (out_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_result(input string name, input acc_t got, input acc_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// serial input, msb first
	//////////////////////////////////////////////////
	task automatic send_all_samples();
		sample_t smp;
		for (int i = 0; i < NUM_SAMPLES; i++)
		begin
			smp = sample_t'(golden_mem[2*i][`FIR_SAMPLE_BITS-1:0]);
			@(negedge clk);
			while (in_busy) @(negedge clk);
			for (int b = `FIR_SAMPLE_BITS - 1; b >= 0; b--)
			begin
				@(posedge clk);
				if (b == `FIR_SAMPLE_BITS - 1 && receiving)
					overlaps++;
				shift_en <= 1'b1;
				data_in  <= smp[b];
			end
			@(posedge clk);
			shift_en <= 1'b0;
			data_in  <= 1'b0;
			// request and ack need at least two more cycles
			repeat (2)
			begin
				@(negedge clk);
				check_bit("in_busy", in_busy, 1'b1);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// serial output with random ack delays
	//////////////////////////////////////////////////
	task automatic receive_all_results();
		acc_t got;
		int   delay;
		for (int r = 0; r < NUM_SAMPLES; r++)
		begin
			for (int b = 0; b < `FIR_ACC_BITS; b++)
			begin
				@(negedge clk);
				while (!out_req) @(negedge clk);
				receiving = 1'b1;
				got[b]    = data_out;
				delay     = $urandom % 6;
				repeat (delay + 1) @(posedge clk);
				out_ack <= 1'b1;
				@(negedge clk);
				while (out_req) @(negedge clk);
				if (b == `FIR_ACC_BITS - 1)
					receiving = 1'b0;
				@(posedge clk);
				out_ack <= 1'b0;
			end
			check_result($sformatf("result[%0d]", r), got, acc_t'(golden_mem[2*r+1]));
		end
	endtask

	// bound assertions stop the run as soon as one fires
	always @(negedge clk)
	begin
		if (dut.u_assert.violations != 0)
		begin
			$display("A protocol assertion failed in the DUT");
			abort_run();
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the DUT stopped making progress");
		abort_run();
	end

	initial
	begin
		clk       = 1'b0;
		reset     = 1'b0;
		shift_en  = 1'b0;
		data_in   = 1'b0;
		out_ack   = 1'b0;
		receiving = 1'b0;
		overlaps  = 0;
		void'($urandom(86));
		$readmemh("verif/fir_golden.txt", golden_mem);
		for (int i = 0; i < 2 * NUM_SAMPLES; i++)
		begin
			if ($isunknown(golden_mem[i]))
			begin
				$display("Golden data file is missing or has too few entries");
				abort_run();
			end
		end

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check_bit("in_busy", in_busy, 1'b0);
		check_bit("out_req", out_req, 1'b0);

		fork
			send_all_samples();
			receive_all_results();
		join

		// no stray bits after the last result
		repeat (20) @(negedge clk);
		check_bit("out_req", out_req, 1'b0);
		check_bit("in_busy", in_busy, 1'b0);

		if (overlaps == 0)
		begin
			$display("No sample was shifted in while a result was being returned");
			abort_run();
		end
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/fir_pkg.sv
hdl/sample_deserializer.sv
hdl/tap_delay_line.sv
hdl/coeff_rom.sv
hdl/fir_mac.sv
hdl/result_serializer.sv
hdl/fir_filter_top.sv
verif/fir_assert.sv
verif/fir_tb.sv

//--- verif/fir_golden.txt
// column 1: 10 bit input sample in hex
// column 2: expected 32 bit result after that sample in hex
001 00000000
000 00000000
000 00000000
000 00000000
000 00000000
000 ffffffff
000 ffffffff
000 00000000
1ff 00000004
200 00000008
3ff 00000003
000 fffffffc
000 fffffff7
000 fffffff5
000 fffffff7
000 000001fb
000 fffffe03
000 00000007
